// ==== files.f ====
verilog/fpu_req_pkg.sv
verilog/fpu_inq_pkg.sv
verilog/inq_ptr_counter.sv
verilog/inq_tag_queue.sv
verilog/fpu_req_decode.sv
verilog/inq_issue_fsm.sv
verilog/pipe_clken_ctl.sv
verilog/fpu_in_ctl.sv
verification/tb_clock_gen.sv
verification/fpu_in_ctl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FPU input control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        --top-module fpu_in_ctl_tb \
        -f files.f \
        -o fpu_in_ctl_sim

./obj_dir/fpu_in_ctl_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench passed" sim.log; then
        exit 0
else
        exit 1
fi

// ==== verification/fpu_in_ctl_tb.sv ====
////////////////////
// Testbench for the FPU input control
// Drives random requests and pipe steps, keeps reference queues of
// the expected tags and checks issue order, hold, one-hot issue and
// clock enables with assertions sampled at the falling edge
////////////////////

`timescale 1ns/10ps

module fpu_in_ctl_tb
        import fpu_req_pkg::*;
        import fpu_inq_pkg::*;
;

        localparam int          QUEUE_DEPTH = DEF_QUEUE_DEPTH;
        localparam int          N_TESTS     = 4;
        localparam int          N_REQ       = 40;         // Requests per traffic test
        localparam logic [15:0] LFSR_SEED   = 16'd33585;

        logic          rclk, reset;
        logic          pcx_data_rdy, pcx_vld, fp_op7;
        fpu_req_type_e pcx_type;
        logic [1:0]    fp_op_hi;
        logic          a1stg_step, m1stg_step, d1stg_step;
        logic          add_active, mul_active, div_active;
        logic          inq_add, inq_mul, inq_div;
        logic          fadd_clken_l, fmul_clken_l, fdiv_clken_l;

        logic [15:0]   lfsr;
        logic [1:0]    pend_hi;                 // Opcode bits follow the strobe by a cycle
        logic          pend_op7;
        fpu_pipe_e     ref_main[$];
        int            div_outstanding, main_reqs, div_reqs, main_pops, div_pops;
        logic          exp_add, exp_mul, exp_div;
        logic [2:0]    inq_prev, hold_prev;     // {div, mul, add} last cycle
        int            errors, test_err_base, tests_passed, tests_failed;

        tb_clock_gen i_clock_gen (.o_clk (rclk), .o_reset (reset));

        fpu_in_ctl #(.QUEUE_DEPTH (QUEUE_DEPTH)) i_dut (
                .rclk (rclk), .i_reset (reset),
                .i_pcx_data_rdy (pcx_data_rdy), .i_pcx_vld (pcx_vld),
                .i_pcx_type (pcx_type), .i_fp_op_hi (fp_op_hi), .i_fp_op7 (fp_op7),
                .i_a1stg_step (a1stg_step), .i_m1stg_step (m1stg_step),
                .i_d1stg_step (d1stg_step), .i_add_pipe_active (add_active),
                .i_mul_pipe_active (mul_active), .i_div_pipe_active (div_active),
                .o_inq_add (inq_add), .o_inq_mul (inq_mul), .o_inq_div (inq_div),
                .o_fadd_clken_l (fadd_clken_l), .o_fmul_clken_l (fmul_clken_l),
                .o_fdiv_clken_l (fdiv_clken_l)
        );

        ////////////////////
        // Helpers
        ////////////////////

        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                if (s[0]) return (s >> 1) ^ 16'hb400;
                return s >> 1;
        endfunction

        // One LFSR step per bit with the newest bit at the bottom
        function automatic logic [7:0] take_bits(input int n);
                logic [7:0] v;
                v = 8'd0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_step(lfsr);
                        v    = {v[6:0], lfsr[0]};
                end
                return v;
        endfunction

        // Target pipe of a request by the packet rules
        function automatic fpu_pipe_e expected_pipe(input logic rdy, input logic vld,
                                                    input logic [4:0] typ,
                                                    input logic [1:0] hi, input logic op7);
                if (!rdy || !vld) return PIPE_NONE;
                if (typ == REQ_TYPE_FPOP1 && op7) return PIPE_ADD;
                if (typ != REQ_TYPE_FPOP2 || op7) return PIPE_NONE;
                if (!hi[1]) return PIPE_ADD;
                if (hi == OP_HI_MUL) return PIPE_MUL;
                return PIPE_DIV;
        endfunction

        function automatic void update_expect();
                exp_add = (ref_main.size() != 0) && (ref_main[0] == PIPE_ADD);
                exp_mul = (ref_main.size() != 0) && (ref_main[0] == PIPE_MUL);
                exp_div = (div_outstanding != 0);
        endfunction

        task automatic report_value(input string name, input int got, input int exp);
                errors++;
                $display("[FAIL] %s: got %0h, expected %0h at %0t", name, got, exp, $time);
        endtask

        // Rising edge plus 1 ns, then new step and busy inputs
        task automatic next_cycle(input logic busy);
                logic [7:0] r;
                @(posedge rclk);
                #1;
                r          = busy ? take_bits(3) : 8'd0;
                a1stg_step = r[0];
                m1stg_step = r[1];
                d1stg_step = r[2];
                r          = busy ? take_bits(6) : 8'hff;
                add_active = (r[1:0] == 2'd0);  // Busy a quarter of the time
                mul_active = (r[3:2] == 2'd0);
                div_active = (r[5:4] == 2'd0);
        endtask

        task automatic drive_idle();
                fp_op_hi     = pend_hi;
                fp_op7       = pend_op7;
                pcx_data_rdy = 1'b0;
                pcx_vld      = 1'b0;
                pend_hi      = 2'b00;
                pend_op7     = 1'b0;
        endtask

        // Mode 0 main only, 1 adds divides, 2 also corrupts requests
        task automatic drive_request(input int mode, output logic sent);
                logic [7:0] r;
                logic       rdy, vld, op7;
                logic [4:0] typ;
                logic [1:0] hi;
                fpu_pipe_e  tag;
                r   = take_bits(4);
                rdy = 1'b1;
                vld = 1'b1;
                hi  = r[3:2];
                op7 = (r[1:0] == 2'd0);
                typ = (r[1:0] == 2'd0) ? REQ_TYPE_FPOP1 : REQ_TYPE_FPOP2;
                if (r[1:0] == 2'd1) hi[1] = 1'b0;
                if (r[1:0] == 2'd2) hi = OP_HI_MUL;
                if (r[1:0] == 2'd3) hi = (mode == 0) ? OP_HI_MUL : OP_HI_DIV;
                r = take_bits(3);
                if (mode == 2 && r[2]) begin
                        case (r[1:0])
                                2'd0: vld = 1'b0;
                                2'd1: rdy = 1'b0;
                                2'd2: begin
                                        r   = take_bits(5);
                                        typ = r[4:0];
                                        if (typ == REQ_TYPE_FPOP1 || typ == REQ_TYPE_FPOP2)
                                                typ = typ ^ 5'h10;
                                end
                                default: op7 = !op7;
                        endcase
                end
                tag  = expected_pipe(rdy, vld, typ, hi, op7);
                sent = 1'b1;
                if ((tag == PIPE_ADD || tag == PIPE_MUL) && ref_main.size() >= QUEUE_DEPTH ||
                    (tag == PIPE_DIV && div_outstanding >= QUEUE_DEPTH)) begin
                        rdy  = 1'b0;            // No room, hold the request back
                        tag  = PIPE_NONE;
                        sent = 1'b0;
                end
                if (tag == PIPE_ADD || tag == PIPE_MUL) begin
                        ref_main.push_back(tag);
                        main_reqs++;
                end else if (tag == PIPE_DIV) begin
                        div_outstanding++;
                        div_reqs++;
                end
                fp_op_hi     = pend_hi;
                fp_op7       = pend_op7;
                pcx_data_rdy = rdy;
                pcx_vld      = vld;
                pcx_type     = fpu_req_type_e'(typ);
                pend_hi      = hi;
                pend_op7     = op7;
                update_expect();
        endtask

        task automatic run_traffic(input int mode);
                int   sent;
                logic ok;
                sent = 0;
                while (sent < N_REQ) begin
                        next_cycle(1'b1);
                        drive_request(mode, ok);
                        if (ok) sent++;
                end
                // Drain until every queued op has been popped
                while (ref_main.size() != 0 || div_outstanding != 0) begin
                        next_cycle(1'b1);
                        drive_idle();
                end
                repeat (4) begin
                        next_cycle(1'b0);
                        drive_idle();
                end
        endtask

        task automatic finish_test(input int num, input string name);
                int n_err;
                assert (main_pops == main_reqs) else report_value("main_pops", main_pops, main_reqs);
                assert (div_pops == div_reqs) else report_value("div_pops", div_pops, div_reqs);
                n_err = errors - test_err_base;
                if (n_err == 0) begin
                        tests_passed++;
                        $display("test %0d %s: ok", num, name);
                end else begin
                        tests_failed++;
                        $display("test %0d %s: %0d errors", num, name, n_err);
                end
                test_err_base = errors;
        endtask

        ////////////////////
        // Monitor
        ////////////////////

        // Pops of this cycle, taken 1 ns after the falling edge
        always @(negedge rclk) begin
                #1;
                inq_prev  = {inq_div, inq_mul, inq_add};
                hold_prev = {inq_div && !d1stg_step, inq_mul && !m1stg_step,
                             inq_add && !a1stg_step};
                if (reset) begin
                        hold_prev = 3'b000;
                end else begin
                        if ((inq_add && a1stg_step) || (inq_mul && m1stg_step)) begin
                                if (ref_main.size() != 0) void'(ref_main.pop_front());
                                main_pops++;
                        end
                        if (inq_div && d1stg_step) begin
                                if (div_outstanding != 0) div_outstanding--;
                                div_pops++;
                        end
                end
                update_expect();
        end

        ////////////////////
        // Assertions
        ////////////////////

        a_add_order: assert property (@(negedge rclk) disable iff (reset) inq_add |-> exp_add)
                else report_value("o_inq_add", int'(inq_add), int'(exp_add));
        a_mul_order: assert property (@(negedge rclk) disable iff (reset) inq_mul |-> exp_mul)
                else report_value("o_inq_mul", int'(inq_mul), int'(exp_mul));
        a_div_issue: assert property (@(negedge rclk) disable iff (reset) inq_div |-> exp_div)
                else report_value("o_inq_div", int'(inq_div), int'(exp_div));
        a_one_hot: assert property (@(negedge rclk) disable iff (reset)
                        $onehot0({inq_div, inq_mul, inq_add}))
                else report_value("o_inq_*", int'({inq_div, inq_mul, inq_add}), 0);
        a_hold: assert property (@(negedge rclk) disable iff (reset)
                        (hold_prev & {inq_div, inq_mul, inq_add}) == hold_prev)
                else report_value("o_inq_* held", int'({inq_div, inq_mul, inq_add}),
                                  int'(hold_prev));
        a_fadd_clken: assert property (@(negedge rclk) disable iff (reset)
                        fadd_clken_l == !(add_active || inq_add || inq_prev[0]))
                else report_value("o_fadd_clken_l", int'(fadd_clken_l),
                                  int'(!(add_active || inq_add || inq_prev[0])));
        a_fmul_clken: assert property (@(negedge rclk) disable iff (reset)
                        fmul_clken_l == !(mul_active || inq_mul || inq_prev[1]))
                else report_value("o_fmul_clken_l", int'(fmul_clken_l),
                                  int'(!(mul_active || inq_mul || inq_prev[1])));
        a_fdiv_clken: assert property (@(negedge rclk) disable iff (reset)
                        fdiv_clken_l == !(div_active || inq_div || inq_prev[2]))
                else report_value("o_fdiv_clken_l", int'(fdiv_clken_l),
                                  int'(!(div_active || inq_div || inq_prev[2])));
        a_reset_clken: assert property (@(negedge rclk)
                        reset |-> ({fadd_clken_l, fmul_clken_l, fdiv_clken_l} == 3'b000))
                else report_value("o_f*_clken_l", int'({fdiv_clken_l, fmul_clken_l,
                                  fadd_clken_l}), 0);

        ////////////////////
        // Tests
        ////////////////////

        initial begin
                lfsr = LFSR_SEED;
                {pcx_data_rdy, pcx_vld, fp_op7, pend_op7} = 4'b0000;
                pcx_type = fpu_req_type_e'(5'h00);
                fp_op_hi = 2'b00;
                pend_hi  = 2'b00;
                {a1stg_step, m1stg_step, d1stg_step} = 3'b000;
                {add_active, mul_active, div_active} = 3'b000;
                {inq_prev, hold_prev} = 6'b000000;
                {div_outstanding, main_reqs, div_reqs, main_pops, div_pops} = '0;
                {errors, test_err_base, tests_passed, tests_failed} = '0;
                update_expect();
                wait (reset === 1'b1);
                wait (reset === 1'b0);

                repeat (12) begin               // Idle after reset
                        next_cycle(1'b0);
                        drive_idle();
                end
                @(negedge rclk);
                assert ({inq_div, inq_mul, inq_add} == 3'b000)
                        else report_value("o_inq_*", int'({inq_div, inq_mul, inq_add}), 0);
                assert ({fdiv_clken_l, fmul_clken_l, fadd_clken_l} == 3'b111)
                        else report_value("o_f*_clken_l", int'({fdiv_clken_l, fmul_clken_l,
                                          fadd_clken_l}), 7);
                finish_test(1, "reset");
                run_traffic(0);
                finish_test(2, "order");
                run_traffic(1);
                finish_test(3, "divide");
                run_traffic(2);
                finish_test(4, "filter");

                $display("tests passed %0d, tests failed %0d, errors %0d",
                         tests_passed, tests_failed, errors);
                if (errors == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

        // Watchdog
        initial begin
                repeat (N_TESTS * 200) @(posedge rclk);
                $display("Timeout: run did not finish within %0d cycles", N_TESTS * 200);
                $display("Testbench failed");
                $finish;
        end

endmodule

// ==== verification/tb_clock_gen.sv ====
////////////////////
// Testbench clock and reset
// Free running 4 ns clock, reset held high for the first
// 8 rising edges and released 1 ns after an edge
////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
        output logic o_clk,
        output logic o_reset
);

        initial begin
                o_clk = 1'b0;
                forever #2 o_clk = ~o_clk;      // 4 ns period
        end

        initial begin
                o_reset = 1'b1;
                repeat (8) @(posedge o_clk);
                #1 o_reset = 1'b0;
        end

endmodule

// ==== verilog/fpu_in_ctl.sv ====
////////////////////
// FPU input control, top level
// Decodes incoming requests into add, multiply and divide tags,
// queues them, issues one head at a time to the pipes and drives
// the per pipe clock enables
////////////////////

`timescale 1ns/10ps

module fpu_in_ctl
        import fpu_req_pkg::*;
        import fpu_inq_pkg::*;
#(
        parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
        input  logic               rclk,
        input  logic               i_reset,
        input  logic               i_pcx_data_rdy,
        input  logic               i_pcx_vld,
        input  fpu_req_type_e      i_pcx_type,
        input  logic [OP_HI_W-1:0] i_fp_op_hi,
        input  logic               i_fp_op7,
        input  logic               i_a1stg_step,
        input  logic               i_m1stg_step,
        input  logic               i_d1stg_step,
        input  logic               i_add_pipe_active,
        input  logic               i_mul_pipe_active,
        input  logic               i_div_pipe_active,
        output logic               o_inq_add,
        output logic               o_inq_mul,
        output logic               o_inq_div,
        output logic               o_fadd_clken_l,     // Clock off when high
        output logic               o_fmul_clken_l,
        output logic               o_fdiv_clken_l
);

        logic      main_we;
        logic      div_we;
        fpu_pipe_e req_pipe;
        logic      main_pop;
        logic      div_pop;
        logic      main_empty;
        logic      div_empty;
        fpu_pipe_e main_head;

        fpu_req_decode i_req_decode (
                .rclk           (rclk),
                .i_reset        (i_reset),
                .i_pcx_data_rdy (i_pcx_data_rdy),
                .i_pcx_vld      (i_pcx_vld),
                .i_pcx_type     (i_pcx_type),
                .i_fp_op_hi     (i_fp_op_hi),
                .i_fp_op7       (i_fp_op7),
                .o_main_we      (main_we),
                .o_div_we       (div_we),
                .o_req_pipe     (req_pipe)
        );

        inq_tag_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_main_queue (
                .rclk (rclk), .i_reset (i_reset), .i_we (main_we), .i_tag (req_pipe),
                .i_pop (main_pop), .o_head (main_head), .o_empty (main_empty)
        );

        // Divide queue head is always a divide, only its empty flag is used
        inq_tag_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_div_queue (
                .rclk (rclk), .i_reset (i_reset), .i_we (div_we), .i_tag (req_pipe),
                .i_pop (div_pop), .o_head (), .o_empty (div_empty)
        );

        inq_issue_fsm i_issue_fsm (
                .rclk (rclk), .i_reset (i_reset),
                .i_main_empty (main_empty), .i_main_head (main_head),
                .i_div_empty (div_empty),
                .i_a1stg_step (i_a1stg_step), .i_m1stg_step (i_m1stg_step),
                .i_d1stg_step (i_d1stg_step), .o_main_pop (main_pop), .o_div_pop (div_pop),
                .o_inq_add (o_inq_add), .o_inq_mul (o_inq_mul), .o_inq_div (o_inq_div)
        );

        pipe_clken_ctl i_clken_ctl (
                .rclk (rclk), .i_reset (i_reset),
                .i_inq_add (o_inq_add), .i_inq_mul (o_inq_mul), .i_inq_div (o_inq_div),
                .i_add_pipe_active (i_add_pipe_active),
                .i_mul_pipe_active (i_mul_pipe_active),
                .i_div_pipe_active (i_div_pipe_active),
                .o_fadd_clken_l (o_fadd_clken_l), .o_fmul_clken_l (o_fmul_clken_l),
                .o_fdiv_clken_l (o_fdiv_clken_l)
        );

endmodule

// ==== verilog/fpu_inq_pkg.sv ====
////////////////////
// Queue side definitions for the FPU input control
// Pipe tags held in the input queues, issue FSM states and the
// default queue depth used by the top level
////////////////////

package fpu_inq_pkg;

        ////////////////////
        // Queue sizing
        ////////////////////

        // Entries per queue, must be a power of two
        localparam int DEF_QUEUE_DEPTH = 8;

        ////////////////////
        // Pipe tag
        ////////////////////

        // One tag per queued request, names the execution pipe
        typedef enum logic [1:0] {
                PIPE_NONE = 2'd0,               // Not an FPU op
                PIPE_ADD  = 2'd1,
                PIPE_MUL  = 2'd2,
                PIPE_DIV  = 2'd3
        } fpu_pipe_e;

        ////////////////////
        // Issue FSM
        ////////////////////

        typedef enum logic {
                ISSUE_MAIN = 1'b0,              // Add and multiply queue
                ISSUE_DIV  = 1'b1               // Divide queue
        } issue_state_e;

endpackage

// ==== verilog/fpu_req_decode.sv ====
////////////////////
// FPU request capture and pipe decode
// Registers the ready strobe, valid bit and packet type, then
// decodes the target pipe and raises the write of the main or
// divide tag queue for one cycle
////////////////////

`timescale 1ns/10ps

module fpu_req_decode
        import fpu_req_pkg::*;
        import fpu_inq_pkg::*;
(
        input  logic                 rclk,
        input  logic                 i_reset,
        input  logic                 i_pcx_data_rdy,   // Request strobe
        input  logic                 i_pcx_vld,
        input  fpu_req_type_e        i_pcx_type,
        input  logic [OP_HI_W-1:0]   i_fp_op_hi,       // Opcode bits 3:2, one cycle later
        input  logic                 i_fp_op7,         // Opcode bit 7, one cycle later
        output logic                 o_main_we,        // Add or multiply tag
        output logic                 o_div_we,         // Divide tag
        output fpu_pipe_e            o_req_pipe
);

        logic          pcx_rdy_q;
        logic          pcx_vld_q;
        fpu_req_type_e pcx_type_q;
        logic          req_ok;
        fpu_pipe_e     req_pipe;

        always_ff @(posedge rclk) begin
                if (i_reset) begin
                        pcx_rdy_q <= 1'b0;
                end else begin
                        pcx_rdy_q <= i_pcx_data_rdy;
                end
        end

        // Header fields of the request
        always_ff @(posedge rclk) begin
                pcx_vld_q  <= i_pcx_vld;
                pcx_type_q <= i_pcx_type;
        end

        assign req_ok = pcx_rdy_q && pcx_vld_q;

        ////////////////////
        // Pipe select
        ////////////////////

        always_comb begin
                req_pipe = PIPE_NONE;
                if (req_ok && (pcx_type_q == REQ_TYPE_FPOP1) && i_fp_op7) begin
                        req_pipe = PIPE_ADD;
                end else if (req_ok && (pcx_type_q == REQ_TYPE_FPOP2) && !i_fp_op7) begin
                        case (i_fp_op_hi)
                                OP_HI_MUL: req_pipe = PIPE_MUL;
                                OP_HI_DIV: req_pipe = PIPE_DIV;
                                default:   req_pipe = PIPE_ADD;   // Bit 3 clear
                        endcase
                end
        end

        assign o_main_we  = (req_pipe == PIPE_ADD) || (req_pipe == PIPE_MUL);
        assign o_div_we   = (req_pipe == PIPE_DIV);
        assign o_req_pipe = req_pipe;

endmodule

// ==== verilog/fpu_req_pkg.sv ====
////////////////////
// Request encodings for the FPU input control
// Packet type and opcode field definitions, imported by the
// request decoder and the top level
////////////////////

package fpu_req_pkg;

        ////////////////////
        // Field widths
        ////////////////////

        localparam int REQ_TYPE_W = 5;          // Packet type field
        localparam int OP_HI_W    = 2;          // Opcode bits 3 and 2

        ////////////////////
        // Packet types
        ////////////////////

        // Only these two types carry FPU work, every other code is ignored
        typedef enum logic [REQ_TYPE_W-1:0] {
                REQ_TYPE_FPOP1 = 5'h0a,         // Add class only, op7 set
                REQ_TYPE_FPOP2 = 5'h0b          // Add, multiply or divide
        } fpu_req_type_e;

        ////////////////////
        // Opcode high bits
        ////////////////////

        // With bit 3 clear the op is add class
        typedef enum logic [OP_HI_W-1:0] {
                OP_HI_MUL = 2'b10,              // Multiply pipe
                OP_HI_DIV = 2'b11               // Divide pipe
        } fpu_op_hi_e;

endpackage

// ==== verilog/inq_issue_fsm.sv ====
////////////////////
// Issue FSM for the FPU input queues
// Presents either the main queue head (add or multiply) or the
// divide queue head to the pipes, and pops it when the pipe steps.
// A presented op stays up until its pipe takes it
////////////////////

`timescale 1ns/10ps

module inq_issue_fsm
        import fpu_inq_pkg::*;
(
        input  logic      rclk,
        input  logic      i_reset,
        input  logic      i_main_empty,
        input  fpu_pipe_e i_main_head,
        input  logic      i_div_empty,
        input  logic      i_a1stg_step,     // Add pipe takes an op
        input  logic      i_m1stg_step,     // Multiply pipe takes an op
        input  logic      i_d1stg_step,     // Divide pipe takes an op
        output logic      o_main_pop,
        output logic      o_div_pop,
        output logic      o_inq_add,
        output logic      o_inq_mul,
        output logic      o_inq_div
);

        issue_state_e state_q;
        issue_state_e state_nxt;
        logic         main_vld;
        logic         main_idle;

        ////////////////////
        // Head presentation
        ////////////////////

        assign main_vld  = (state_q == ISSUE_MAIN) && !i_main_empty;

        assign o_inq_add = main_vld && (i_main_head == PIPE_ADD);
        assign o_inq_mul = main_vld && (i_main_head == PIPE_MUL);
        assign o_inq_div = (state_q == ISSUE_DIV) && !i_div_empty;

        // Pop on the step of the pipe being presented to
        assign o_main_pop = (o_inq_add && i_a1stg_step)
                        || (o_inq_mul && i_m1stg_step);
        assign o_div_pop  = o_inq_div && i_d1stg_step;

        // No main op left waiting, so switching cannot drop a held op
        assign main_idle = !main_vld || o_main_pop;

        ////////////////////
        // State
        ////////////////////

        always_comb begin
                state_nxt = state_q;
                case (state_q)
                        ISSUE_MAIN: begin
                                if (!i_div_empty && i_d1stg_step && main_idle) begin
                                        state_nxt = ISSUE_DIV;
                                end
                        end
                        ISSUE_DIV: begin
                                if (o_div_pop) begin
                                        state_nxt = ISSUE_MAIN;   // One divide per visit
                                end
                        end
                        default: state_nxt = ISSUE_MAIN;
                endcase
        end

        always_ff @(posedge rclk) begin
                if (i_reset) begin
                        state_q <= ISSUE_MAIN;
                end else begin
                        state_q <= state_nxt;
                end
        end

endmodule

// ==== verilog/inq_ptr_counter.sv ====
////////////////////
// Input queue pointer
// Binary pointer with one wrap bit above the entry address,
// cleared on reset and advanced by one on each step
////////////////////

`timescale 1ns/10ps

module inq_ptr_counter
        import fpu_inq_pkg::*;
#(
        parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
        localparam int PTR_W      = $clog2(QUEUE_DEPTH) + 1
) (
        input  logic             rclk,
        input  logic             i_reset,
        input  logic             i_step,          // Advance by one entry
        output logic [PTR_W-1:0] o_ptr            // Wrap bit on top
);

        logic [PTR_W-1:0] ptr_q;

        // Power of two depth, so plain overflow gives the wrap
        always_ff @(posedge rclk) begin
                if (i_reset) begin
                        ptr_q <= '0;
                end else if (i_step) begin
                        ptr_q <= ptr_q + 1'b1;
                end
        end

        assign o_ptr = ptr_q;

endmodule

// ==== verilog/inq_tag_queue.sv ====
////////////////////
// Input queue of pipe tags
// Small register FIFO written in arrival order and popped by the
// issue FSM. An entry shows at the head one cycle after its write
////////////////////

`timescale 1ns/10ps

module inq_tag_queue
        import fpu_inq_pkg::*;
#(
        parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
        input  logic      rclk,
        input  logic      i_reset,
        input  logic      i_we,
        input  fpu_pipe_e i_tag,
        input  logic      i_pop,        // Only raised while non-empty
        output fpu_pipe_e o_head,
        output logic      o_empty
);

        localparam int ADDR_W = $clog2(QUEUE_DEPTH);
        localparam int PTR_W  = ADDR_W + 1;

        fpu_pipe_e        tag_mem [QUEUE_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr_vis;           // Write pointer seen by the reader

        ////////////////////
        // Pointers
        ////////////////////

        inq_ptr_counter #(
                .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_wr_ptr (
                .rclk    (rclk),
                .i_reset (i_reset),
                .i_step  (i_we),
                .o_ptr   (wr_ptr)
        );

        inq_ptr_counter #(
                .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_rd_ptr (
                .rclk    (rclk),
                .i_reset (i_reset),
                .i_step  (i_pop),
                .o_ptr   (rd_ptr)
        );

        // One cycle behind the write pointer
        always_ff @(posedge rclk) begin
                if (i_reset) begin
                        wr_ptr_vis <= '0;
                end else begin
                        wr_ptr_vis <= wr_ptr;
                end
        end

        ////////////////////
        // Tag storage
        ////////////////////

        always_ff @(posedge rclk) begin
                if (i_we) begin
                        tag_mem[wr_ptr[ADDR_W-1:0]] <= i_tag;
                end
        end

        assign o_head  = tag_mem[rd_ptr[ADDR_W-1:0]];
        assign o_empty = (wr_ptr_vis == rd_ptr);  // Wrap bit included

endmodule

// ==== verilog/pipe_clken_ctl.sv ====
////////////////////
// Per pipe clock enables, active low
// A pipe clock runs while the pipe is busy, while it is issued
// to and for one cycle after, and always during reset
////////////////////

`timescale 1ns/10ps

module pipe_clken_ctl (
        input  logic rclk,
        input  logic i_reset,
        input  logic i_inq_add,
        input  logic i_inq_mul,
        input  logic i_inq_div,
        input  logic i_add_pipe_active,
        input  logic i_mul_pipe_active,
        input  logic i_div_pipe_active,
        output logic o_fadd_clken_l,
        output logic o_fmul_clken_l,
        output logic o_fdiv_clken_l
);

        logic [2:0] issue_dly;                  // {div, mul, add} last cycle

        always_ff @(posedge rclk) begin
                if (i_reset) begin
                        issue_dly <= 3'b000;
                end else begin
                        issue_dly <= {i_inq_div, i_inq_mul, i_inq_add};
                end
        end

        assign o_fadd_clken_l = !(i_add_pipe_active || i_inq_add
                                  || issue_dly[0] || i_reset);
        assign o_fmul_clken_l = !(i_mul_pipe_active || i_inq_mul
                                  || issue_dly[1] || i_reset);
        assign o_fdiv_clken_l = !(i_div_pipe_active || i_inq_div
                                  || issue_dly[2] || i_reset);

endmodule
